// File: hw/game_pkg.sv
`default_nettype none

package game_pkg;

	// --------------------
	// screen and scan
	// --------------------
	localparam int coord_w = 10;
	// signed width for column math with rel_x
	localparam int sx_w = coord_w + 3;
	localparam logic [coord_w-1:0] x_last = 10'd799;
	localparam logic [coord_w-1:0] y_last = 10'd599;

	// playfield frame
	localparam logic [coord_w-1:0] border_lo = 10'd80;
	localparam logic [coord_w-1:0] border_hi = 10'd720;
	localparam logic [coord_w-1:0] stripe_lo_a = 10'd80;
	localparam logic [coord_w-1:0] stripe_hi_a = 10'd100;
	localparam logic [coord_w-1:0] stripe_lo_b = 10'd700;
	localparam logic [coord_w-1:0] stripe_hi_b = 10'd720;
	// stripe bands repeat every 100 rows, 80 rows long
	localparam logic [coord_w-1:0] stripe_period = 10'd100;
	localparam logic [coord_w-1:0] stripe_len = 10'd80;
	localparam int stripe_bands = 5;

	// --------------------
	// lanes
	// --------------------
	localparam int lane_count = 5;
	localparam logic [coord_w-1:0] lane_base_y = 10'd579;
	localparam logic [coord_w-1:0] lane_height = 10'd20;
	// lane 4 is the only one running out of reset
	localparam logic [lane_count-1:0] lane_en_init = 5'b10000;
	localparam logic [lane_count-1:0][coord_w-1:0] lane_x1 =
		{10'd500, 10'd450, 10'd300, 10'd200, 10'd100};
	localparam logic [lane_count-1:0][coord_w-1:0] lane_x2 =
		{10'd700, 10'd650, 10'd500, 10'd400, 10'd300};
	localparam logic [coord_w-1:0] landing_margin = 10'd25;
	localparam logic [coord_w-1:0] landing_gap = 10'd8;
	// launch targets, entry 0 on the right
	localparam logic [15:0][1:0] lane_table = {
		2'd2, 2'd1, 2'd3, 2'd3, 2'd0, 2'd2, 2'd1, 2'd3,
		2'd0, 2'd2, 2'd1, 2'd1, 2'd0, 2'd2, 2'd3, 2'd0
	};

	// player box
	localparam logic [coord_w-1:0] player_x1 = 10'd375;
	localparam logic [coord_w-1:0] player_x2 = 10'd425;
	localparam logic [coord_w-1:0] player_height = 10'd50;
	localparam logic [coord_w-1:0] player_start_y = 10'd10;
	localparam logic [coord_w-1:0] player_end_y = 10'd577;

	// --------------------
	// colours, rrrgggbb
	// --------------------
	localparam logic [7:0] col_black = 8'h00;
	localparam logic [7:0] col_border = 8'h8b;
	localparam logic [7:0] col_stripe = 8'h1a;
	localparam logic [7:0] col_obstacle = 8'h1c;
	localparam logic [7:0] col_player = 8'he0;
	localparam logic [7:0] col_back = 8'hff;
	localparam logic [7:0] col_end = 8'hdc;

	typedef struct packed {
		logic [2:0] step;
		logic [3:0] wrap_gap;
		logic [8:0] launch_gap;
	} speed_cfg_t;

	typedef struct packed {
		logic [lane_count-1:0] en;
		logic [lane_count-1:0][coord_w-1:0] offset;
	} lanes_t;

	typedef struct packed {
		logic [coord_w-1:0] y_top;
		logic touching;
		logic ended;
	} player_t;

	function automatic speed_cfg_t speed_of(input logic [1:0] sw);
		speed_cfg_t cfg;
		case (sw)
			2'd0: cfg = '{step: 3'd2, wrap_gap: 4'd3, launch_gap: 9'd379};
			2'd1: cfg = '{step: 3'd3, wrap_gap: 4'd3, launch_gap: 9'd381};
			2'd2: cfg = '{step: 3'd4, wrap_gap: 4'd7, launch_gap: 9'd379};
			default: cfg = '{step: 3'd5, wrap_gap: 4'd9, launch_gap: 9'd379};
		endcase
		return cfg;
	endfunction

	// zero extend a coordinate into signed column space
	function automatic logic signed [sx_w-1:0] to_sx(input logic [coord_w-1:0] v);
		return $signed({{(sx_w-coord_w){1'b0}}, v});
	endfunction

	// player column edge after the rel_x shift
	function automatic logic signed [sx_w-1:0] shift_col(
		input logic [coord_w-1:0] col,
		input logic signed [coord_w+1:0] rel_x
	);
		return to_sx(col) - $signed({rel_x[coord_w+1], rel_x});
	endfunction

endpackage

`default_nettype wire

// File: hw/obstacle_field.sv
`timescale 1ns/1ps
`default_nettype none

module obstacle_field (
	input  logic                         clk_50m,
	input  logic                         rst,
	input  logic                         pause,
	input  logic [1:0]                   sw,
	input  logic [game_pkg::coord_w:0]   vector_x,
	input  logic [game_pkg::coord_w-1:0] vector_y,
	output game_pkg::lanes_t             lanes
);

	game_pkg::speed_cfg_t cfg;
	logic [game_pkg::coord_w-1:0] step;
	logic [game_pkg::coord_w-1:0] wrap_at;
	logic [game_pkg::coord_w-1:0] launch_at;
	logic frame_end;
	logic [3:0] seq_idx;
	logic [3:0] seq_idx_n;
	game_pkg::lanes_t lanes_n;

	// --------------------
	// speed setting
	// --------------------
	assign cfg = game_pkg::speed_of(sw);
	// widen the table fields to offset width
	assign step = {{(game_pkg::coord_w-3){1'b0}}, cfg.step};
	assign wrap_at = game_pkg::lane_base_y -
		{{(game_pkg::coord_w-4){1'b0}}, cfg.wrap_gap};
	assign launch_at = game_pkg::lane_base_y -
		{{(game_pkg::coord_w-9){1'b0}}, cfg.launch_gap};

	// last visible pixel of the frame
	assign frame_end = (vector_x == {1'b0, game_pkg::x_last}) &&
		(vector_y == game_pkg::y_last);

	// lane launched by lane 'lane' for a given table entry
	function automatic logic [2:0] target_of(input int lane, input logic [1:0] entry);
		logic [3:0] sum;
		sum = 4'(lane) + 4'd1 + {2'b00, entry};
		// mod lane_count, sum never reaches twice the count
		if (sum >= 4'(game_pkg::lane_count)) begin
			sum = sum - 4'(game_pkg::lane_count);
		end
		return sum[2:0];
	endfunction

	// --------------------
	// next lane state
	// --------------------
	// lanes handled in ascending order
	// each event sees the index left by the ones before it
	always_comb begin
		lanes_n = lanes;
		seq_idx_n = seq_idx;
		for (int i = 0; i < game_pkg::lane_count; i++) begin
			if (lanes.en[i]) begin
				if (lanes.offset[i] == wrap_at) begin
					// reached the top, retire
					lanes_n.offset[i] = '0;
					lanes_n.en[i] = 1'b0;
					seq_idx_n = seq_idx_n + 4'd1;
				end else begin
					lanes_n.offset[i] = lanes.offset[i] + step;
				end
				// launch height uses the offset before the step
				if (lanes.offset[i] == launch_at) begin
					lanes_n.en[target_of(i, game_pkg::lane_table[seq_idx_n])] = 1'b1;
					// index moves on even when target already runs
					seq_idx_n = seq_idx_n + 4'd1;
				end
			end
		end
	end

	// --------------------
	// state registers
	// --------------------
	// one update per frame, frozen while paused
	always_ff @(posedge clk_50m or negedge rst) begin
		if (!rst) begin
			lanes.en <= game_pkg::lane_en_init;
			lanes.offset <= '0;
			seq_idx <= '0;
		end else if (frame_end && !pause) begin
			lanes <= lanes_n;
			seq_idx <= seq_idx_n;
		end
	end

endmodule

`default_nettype wire

// File: hw/player_motion.sv
`timescale 1ns/1ps
`default_nettype none

module player_motion (
	input  logic                              clk_50m,
	input  logic                              rst,
	input  logic                              pause,
	input  logic [1:0]                        sw,
	input  logic [game_pkg::coord_w:0]        vector_x,
	input  logic [game_pkg::coord_w-1:0]      vector_y,
	input  logic signed [game_pkg::coord_w+1:0] rel_x,
	input  game_pkg::lanes_t                  lanes,
	output game_pkg::player_t                 player
);

	game_pkg::speed_cfg_t cfg;
	logic [game_pkg::coord_w-1:0] step;
	logic frame_start;
	logic signed [game_pkg::sx_w-1:0] box_x1;
	logic signed [game_pkg::sx_w-1:0] box_x2;
	logic [game_pkg::coord_w-1:0] box_bottom;
	logic hit;

	assign cfg = game_pkg::speed_of(sw);
	assign step = {{(game_pkg::coord_w-3){1'b0}}, cfg.step};

	// first pixel of the frame
	assign frame_start = (vector_x == '0) && (vector_y == '0);

	// box columns after the player shift
	assign box_x1 = game_pkg::shift_col(game_pkg::player_x1, rel_x);
	assign box_x2 = game_pkg::shift_col(game_pkg::player_x2, rel_x);
	assign box_bottom = player.y_top + game_pkg::player_height;

	// --------------------
	// landing test
	// --------------------
	always_comb begin : landing
		logic signed [game_pkg::sx_w-1:0] lo;
		logic signed [game_pkg::sx_w-1:0] hi;
		logic signed [game_pkg::sx_w-1:0] gap;
		hit = 1'b0;
		for (int i = 0; i < game_pkg::lane_count; i++) begin
			// lane span widened by the margin on both sides
			lo = game_pkg::to_sx(game_pkg::lane_x1[i]) -
				game_pkg::to_sx(game_pkg::landing_margin);
			hi = game_pkg::to_sx(game_pkg::lane_x2[i]) +
				game_pkg::to_sx(game_pkg::landing_margin);
			// lane top row minus box bottom
			gap = game_pkg::to_sx(game_pkg::lane_base_y - lanes.offset[i]) -
				game_pkg::to_sx(box_bottom);
			if (lanes.en[i] && (lo <= box_x1) && (box_x2 <= hi) &&
				(gap >= 0) && (gap <= game_pkg::to_sx(game_pkg::landing_gap))) begin
				hit = 1'b1;
			end
		end
	end

	// --------------------
	// box height and end latch
	// --------------------
	always_ff @(posedge clk_50m or negedge rst) begin
		if (!rst) begin
			player.y_top <= game_pkg::player_start_y;
			player.touching <= 1'b0;
			player.ended <= 1'b0;
		end else begin
			player.touching <= hit;
			// sticky until reset
			if (player.y_top > game_pkg::player_end_y) begin
				player.ended <= 1'b1;
			end
			if (frame_start && !player.ended && !pause) begin
				if (player.y_top + game_pkg::lane_height > game_pkg::y_last) begin
					// fell off the screen, back to start
					player.y_top <= game_pkg::player_start_y;
				end else if (player.touching) begin
					// carried up, top edge holds at row zero
					if (player.y_top < step) begin
						player.y_top <= '0;
					end else begin
						player.y_top <= player.y_top - step;
					end
				end else begin
					player.y_top <= player.y_top + step;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/pixel_composer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_composer (
	input  logic                              clk_50m,
	input  logic                              rst,
	input  logic [game_pkg::coord_w:0]        vector_x,
	input  logic [game_pkg::coord_w-1:0]      vector_y,
	input  logic signed [game_pkg::coord_w+1:0] rel_x,
	input  game_pkg::lanes_t                  lanes,
	input  game_pkg::player_t                 player,
	output logic [2:0]                        vga_red,
	output logic [2:0]                        vga_green,
	output logic [1:0]                        vga_blue
);

	logic [7:0] colour;
	logic [7:0] colour_q;
	logic signed [game_pkg::sx_w-1:0] scan_x;

	// scan column in signed space, never negative
	assign scan_x = $signed({{(game_pkg::sx_w-game_pkg::coord_w-1){1'b0}}, vector_x});

	// --------------------
	// colour choice
	// --------------------
	always_comb begin : pick
		logic stripe_col;
		logic stripe_row;
		logic in_lane;
		logic in_box;
		logic [game_pkg::coord_w-1:0] band_lo;
		logic [game_pkg::coord_w-1:0] top;
		// inner side bands
		stripe_col = ((vector_x > game_pkg::stripe_lo_a) && (vector_x < game_pkg::stripe_hi_a)) ||
			((vector_x > game_pkg::stripe_lo_b) && (vector_x < game_pkg::stripe_hi_b));
		// first band starts at row zero, the rest open strictly
		stripe_row = vector_y < game_pkg::stripe_len;
		band_lo = game_pkg::stripe_period;
		for (int k = 0; k < game_pkg::stripe_bands; k++) begin
			if ((vector_y > band_lo) && (vector_y < band_lo + game_pkg::stripe_len)) begin
				stripe_row = 1'b1;
			end
			band_lo = band_lo + game_pkg::stripe_period;
		end
		// obstacles, all edges exclusive
		in_lane = 1'b0;
		for (int i = 0; i < game_pkg::lane_count; i++) begin
			top = game_pkg::lane_base_y - lanes.offset[i];
			if (lanes.en[i] &&
				(vector_x > game_pkg::lane_x1[i]) && (vector_x < game_pkg::lane_x2[i]) &&
				(vector_y > top) && (vector_y < top + game_pkg::lane_height)) begin
				in_lane = 1'b1;
			end
		end
		// player box, columns inclusive
		in_box = (game_pkg::shift_col(game_pkg::player_x1, rel_x) <= scan_x) &&
			(scan_x <= game_pkg::shift_col(game_pkg::player_x2, rel_x)) &&
			(vector_y >= player.y_top) &&
			(vector_y < player.y_top + game_pkg::player_height);

		// priority order, frame first
		if ((vector_x > game_pkg::x_last) || (vector_y > game_pkg::y_last)) begin
			colour = game_pkg::col_black;
		end else if ((vector_x <= game_pkg::border_lo) || (vector_x >= game_pkg::border_hi)) begin
			colour = game_pkg::col_border;
		end else if (stripe_col && stripe_row) begin
			colour = game_pkg::col_stripe;
		end else if (player.ended) begin
			colour = game_pkg::col_end;
		end else if (in_lane) begin
			colour = game_pkg::col_obstacle;
		end else if (in_box) begin
			colour = game_pkg::col_player;
		end else begin
			colour = game_pkg::col_back;
		end
	end

	// one cycle behind the scan
	always_ff @(posedge clk_50m or negedge rst) begin
		if (!rst) begin
			colour_q <= game_pkg::col_black;
		end else begin
			colour_q <= colour;
		end
	end

	assign {vga_red, vga_green, vga_blue} = colour_q;

endmodule

`default_nettype wire

// File: hw/vga_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_game_top (
	input  logic                              clk_50m,
	input  logic                              rst,
	input  logic                              pause,
	input  logic [1:0]                        sw,
	input  logic [game_pkg::coord_w:0]        vector_x,
	input  logic [game_pkg::coord_w-1:0]      vector_y,
	input  logic signed [game_pkg::coord_w+1:0] rel_x,
	output logic [2:0]                        vga_red,
	output logic [2:0]                        vga_green,
	output logic [1:0]                        vga_blue,
	output logic                              endgame
);

	game_pkg::lanes_t lanes;
	game_pkg::player_t player;

	// --------------------
	// lane engine
	// --------------------
	obstacle_field obstacle_field_i (
		.clk_50m  (clk_50m),
		.rst      (rst),
		.pause    (pause),
		.sw       (sw),
		.vector_x (vector_x),
		.vector_y (vector_y),
		.lanes    (lanes)
	);

	// player reads the lanes for landing
	player_motion player_motion_i (
		.clk_50m  (clk_50m),
		.rst      (rst),
		.pause    (pause),
		.sw       (sw),
		.vector_x (vector_x),
		.vector_y (vector_y),
		.rel_x    (rel_x),
		.lanes    (lanes),
		.player   (player)
	);

	// --------------------
	// pixel output
	// --------------------
	pixel_composer pixel_composer_i (
		.clk_50m   (clk_50m),
		.rst       (rst),
		.vector_x  (vector_x),
		.vector_y  (vector_y),
		.rel_x     (rel_x),
		.lanes     (lanes),
		.player    (player),
		.vga_red   (vga_red),
		.vga_green (vga_green),
		.vga_blue  (vga_blue)
	);

	assign endgame = player.ended;

endmodule

`default_nettype wire

// File: verification/vga_game_props.sv
`timescale 1ns/1ps
`default_nettype none

module vga_game_props (
	input logic              clk_50m,
	input logic              rst,
	input logic [2:0]        vga_red,
	input logic [2:0]        vga_green,
	input logic [1:0]        vga_blue,
	input game_pkg::player_t player
);

	// failed assertions so far, polled by the testbench
	int error_count = 0;

	// output register held black in reset
	reset_black: assert property (@(negedge clk_50m)
		!rst |-> ({vga_red, vga_green, vga_blue} == 8'h00))
		else begin
			$error("rgb not black while reset is low");
			error_count++;
		end

	// end of game is sticky
	end_sticky: assert property (@(posedge clk_50m) disable iff (!rst)
		player.ended |=> player.ended)
		else begin
			$error("endgame fell without reset");
			error_count++;
		end

	// box top stays on the screen
	top_on_screen: assert property (@(posedge clk_50m) disable iff (!rst)
		player.y_top <= game_pkg::y_last)
		else begin
			$error("player top row beyond the last line");
			error_count++;
		end

endmodule

bind pixel_composer vga_game_props props_i (
	.clk_50m   (clk_50m),
	.rst       (rst),
	.vga_red   (vga_red),
	.vga_green (vga_green),
	.vga_blue  (vga_blue),
	.player    (player)
);

`default_nettype wire

// File: verification/vga_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vga_game_tb;

	// --------------------
	// run lengths
	// --------------------
	localparam int period_ns = 20;
	localparam int speed_frames = 400;
	localparam int table_frames = 200;
	localparam int land_frames = 160;
	localparam int end_frames = 140;
	// spare frames for the reset checks, resets and end screen samples
	localparam int total_frames =
		4 * speed_frames + table_frames + land_frames + end_frames + 40;
	localparam int frame_cycles = 8;
	localparam int cycle_limit = total_frames * frame_cycles * 2;

	logic clk_50m;
	logic rst;
	logic pause;
	logic [1:0] sw;
	logic [10:0] vector_x;
	logic [9:0] vector_y;
	logic signed [11:0] rel_x;
	logic [2:0] vga_red;
	logic [2:0] vga_green;
	logic [1:0] vga_blue;
	logic endgame;

	// speed rows, lane spans and launch table
	int step_tbl [4] = '{2, 3, 4, 5};
	int wrap_tbl [4] = '{3, 3, 7, 9};
	int launch_tbl [4] = '{379, 381, 379, 379};
	int lx1 [5] = '{100, 200, 300, 450, 500};
	int lx2 [5] = '{300, 400, 500, 650, 700};
	int lane_tbl [16] = '{0, 3, 2, 0, 1, 1, 2, 0, 3, 1, 2, 0, 3, 3, 1, 2};

	// model state, mirrors the DUT after each rising edge
	bit [4:0] m_en;
	int m_off [5];
	int m_seq;
	int m_y;
	bit m_touch;
	bit m_ended;
	int m_rel;
	int launches;
	int retires;
	int landed_frames;

	int seed;
	int exp_col;
	bit pending;
	string test_name;
	int cycle_count = 0;

	vga_game_top dut_i (
		.clk_50m   (clk_50m),
		.rst       (rst),
		.pause     (pause),
		.sw        (sw),
		.vector_x  (vector_x),
		.vector_y  (vector_y),
		.rel_x     (rel_x),
		.vga_red   (vga_red),
		.vga_green (vga_green),
		.vga_blue  (vga_blue),
		.endgame   (endgame)
	);

	initial begin
		clk_50m = 1'b0;
		forever #(period_ns / 2) clk_50m = ~clk_50m;
	end

	// --------------------
	// failure reporting
	// --------------------
	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
			stop_with_failure();
		end
	endtask

	always @(posedge clk_50m) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Error: run did not finish within %0d cycles", cycle_limit);
			stop_with_failure();
		end
	end

	function automatic int rand_in(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return lo + r % (hi - lo + 1);
	endfunction

	// --------------------
	// reference model
	// --------------------
	function automatic int expect_colour(input int x, input int y);
		bit stripe_c;
		bit stripe_r;
		bit lane_hit;
		int top;
		stripe_c = (x > 80 && x < 100) || (x > 700 && x < 720);
		stripe_r = (y < 80);
		for (int k = 1; k <= 5; k++) begin
			if (y > 100 * k && y < 100 * k + 80) begin
				stripe_r = 1'b1;
			end
		end
		lane_hit = 1'b0;
		for (int i = 0; i < 5; i++) begin
			top = 579 - m_off[i];
			if (m_en[i] && x > lx1[i] && x < lx2[i] && y > top && y < top + 20) begin
				lane_hit = 1'b1;
			end
		end
		if (x > 799 || y > 599) begin
			return 8'h00;
		end else if (x <= 80 || x >= 720) begin
			return 8'h8b;
		end else if (stripe_c && stripe_r) begin
			return 8'h1a;
		end else if (m_ended) begin
			return 8'hdc;
		end else if (lane_hit) begin
			return 8'h1c;
		end else if (x >= 375 - m_rel && x <= 425 - m_rel && y >= m_y && y < m_y + 50) begin
			return 8'he0;
		end
		return 8'hff;
	endfunction

	// next state for one rising edge at scan position (x, y)
	task automatic model_clock(input int x, input int y);
		bit [4:0] en_n;
		int off_n [5];
		int seq_n;
		int y_n;
		int stp;
		int gap;
		bit hit;
		stp = step_tbl[sw];
		hit = 1'b0;
		for (int i = 0; i < 5; i++) begin
			gap = (579 - m_off[i]) - (m_y + 50);
			if (m_en[i] && lx1[i] - 25 <= 375 - m_rel && 425 - m_rel <= lx2[i] + 25 &&
				gap >= 0 && gap <= 8) begin
				hit = 1'b1;
			end
		end
		// player moves on the frame start
		y_n = m_y;
		if (x == 0 && y == 0 && !m_ended && !pause) begin
			if (m_y + 20 > 599) begin
				y_n = 10;
			end else if (m_touch) begin
				y_n = (m_y < stp) ? 0 : m_y - stp;
				landed_frames++;
			end else begin
				y_n = m_y + stp;
			end
		end
		// lanes move on the frame end, lowest lane first
		en_n = m_en;
		off_n = m_off;
		seq_n = m_seq;
		if (x == 799 && y == 599 && !pause) begin
			for (int i = 0; i < 5; i++) begin
				if (m_en[i]) begin
					if (m_off[i] == 579 - wrap_tbl[sw]) begin
						off_n[i] = 0;
						en_n[i] = 1'b0;
						seq_n = (seq_n + 1) % 16;
						retires++;
					end else begin
						off_n[i] = (m_off[i] + stp) % 1024;
					end
					if (m_off[i] == 579 - launch_tbl[sw]) begin
						en_n[(i + 1 + lane_tbl[seq_n]) % 5] = 1'b1;
						seq_n = (seq_n + 1) % 16;
						launches++;
					end
				end
			end
		end
		if (m_y > 577) begin
			m_ended = 1'b1;
		end
		m_touch = hit;
		m_y = y_n;
		m_en = en_n;
		m_off = off_n;
		m_seq = seq_n;
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic check_pending();
		if (dut_i.pixel_composer_i.props_i.error_count != 0) begin
			$display("Error: a bound assertion failed during %s", test_name);
			stop_with_failure();
		end
		if (pending) begin
			check_value("colour", exp_col, {vga_red, vga_green, vga_blue});
			check_value("endgame", m_ended, endgame);
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic scan_cycle(input int x, input int y);
		check_pending();
		vector_x = 11'(x);
		vector_y = 10'(y);
		exp_col = expect_colour(x, y);
		model_clock(x, y);
		pending = 1'b1;
		@(posedge clk_50m);
		@(negedge clk_50m);
	endtask

	task automatic apply_reset(input int sw_val, input int rel);
		check_pending();
		rst = 1'b0;
		pause = 1'b0;
		sw = 2'(sw_val);
		rel_x = 12'(rel);
		vector_x = '0;
		vector_y = '0;
		m_rel = rel;
		m_en = 5'b10000;
		for (int i = 0; i < 5; i++) begin
			m_off[i] = 0;
		end
		m_seq = 0;
		m_y = 10;
		m_touch = 1'b0;
		m_ended = 1'b0;
		launches = 0;
		retires = 0;
		landed_frames = 0;
		pending = 1'b0;
		repeat (4) @(negedge clk_50m);
		rst = 1'b1;
	endtask

	task automatic frame_strobes(input bit with_start);
		scan_cycle(799, 599);
		if (with_start) begin
			scan_cycle(0, 0);
		end
	endtask

	// a pixel near the obstacle rows of one lane
	task automatic sample_lane(input int i);
		scan_cycle(rand_in(lx1[i] - 1, lx2[i] + 1), 579 - m_off[i] + rand_in(-1, 20));
	endtask

	// box corners and the row just below it
	task automatic sample_box();
		scan_cycle(375 - m_rel, m_y);
		scan_cycle(425 - m_rel, m_y + 49);
		scan_cycle(374 - m_rel, m_y + rand_in(0, 49));
		scan_cycle(rand_in(375 - m_rel, 425 - m_rel), m_y + 50);
	endtask

	initial begin
		rst = 1'b0;
		pause = 1'b0;
		sw = 2'd0;
		vector_x = '0;
		vector_y = '0;
		rel_x = '0;
		pending = 1'b0;
		seed = 26210;

		// fixed colours straight after reset
		test_name = "reset_colours";
		apply_reset(0, 0);
		scan_cycle(40, 300);
		scan_cycle(760, 20);
		scan_cycle(90, 50);
		scan_cycle(710, 150);
		scan_cycle(900, 100);
		scan_cycle(300, 650);
		scan_cycle(150, 300);
		scan_cycle(400, 30);
		repeat (16) scan_cycle(rand_in(0, 849), rand_in(0, 619));
		check_value("endgame", 0, endgame);

		// lane 4 speed per sw, with random pause frames
		test_name = "lane_speed";
		for (int s = 0; s < 4; s++) begin
			apply_reset(s, 0);
			repeat (speed_frames) begin
				pause = (rand_in(0, 7) == 0);
				frame_strobes(1'b0);
				sample_lane(4);
				sample_lane(4);
				sample_lane(rand_in(0, 4));
				repeat (3) scan_cycle(rand_in(0, 849), rand_in(0, 619));
			end
		end
		pause = 1'b0;

		// launch and retire through the lane table
		test_name = "lane_table";
		apply_reset(3, 0);
		repeat (table_frames) begin
			frame_strobes(1'b0);
			for (int i = 0; i < 5; i++) begin
				scan_cycle((lx1[i] + lx2[i]) / 2, 589 - m_off[i]);
			end
			scan_cycle(rand_in(0, 849), rand_in(0, 619));
		end
		if (launches < 2 || retires < 2) begin
			$display("Error: lane_table saw %0d launches and %0d retires", launches, retires);
			stop_with_failure();
		end

		// box over lane 4, lands and rides it up
		test_name = "player_landing";
		apply_reset(2, -200);
		repeat (land_frames) begin
			frame_strobes(1'b1);
			sample_box();
			scan_cycle(rand_in(0, 849), rand_in(0, 619));
			scan_cycle(rand_in(500, 700), 579 - m_off[4] + rand_in(-1, 20));
		end
		if (landed_frames == 0) begin
			$display("Error: player_landing never carried the box on a lane");
			stop_with_failure();
		end

		// box clear of every lane falls to the bottom
		test_name = "end_screen";
		apply_reset(3, -400);
		repeat (end_frames) begin
			frame_strobes(1'b1);
			scan_cycle(rand_in(0, 849), rand_in(0, 619));
			scan_cycle(rand_in(101, 699), m_y + rand_in(0, 49));
		end
		check_value("endgame", 1, endgame);
		repeat (10) scan_cycle(rand_in(101, 699), rand_in(0, 599));
		repeat (5) scan_cycle(rand_in(0, 80), rand_in(0, 599));
		repeat (5) scan_cycle(rand_in(720, 799), rand_in(0, 599));

		check_pending();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hw/game_pkg.sv
hw/obstacle_field.sv
hw/player_motion.sv
hw/pixel_composer.sv
hw/vga_game_top.sv
verification/vga_game_props.sv
verification/vga_game_tb.sv
